/* Makefile */
TOOL  ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal
TOP   ?= cps_video_tb
FLIST ?= cps_video.f
LOG   ?= sim.log

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o V$(TOP)

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* cps_video.f */
verilog/cps_video_pkg.sv
verilog/video_timing.sv
verilog/video_regs.sv
verilog/layer_mixer.sv
verilog/palette_lookup.sv
verilog/cps_video.sv
dv/cps_video_properties.sv
dv/cps_video_checker.sv
dv/cps_video_tb.sv

/* dv/cps_video_checker.sv */
// Reference model of timing, registers and palette with a delayed compare of DUT outputs
module cps_video_checker import cps_video_pkg::*; #(
    parameter int H_TOTAL  = 64,
    parameter int H_ACTIVE = 48,
    parameter int V_TOTAL  = 40,
    parameter int V_ACTIVE = 32
) (
    input logic              clk,
    input logic              rst,
    input logic              wb_cyc,
    input logic              wb_stb,
    input logic              wb_we,
    input logic              wb_ack,
    input logic [ADDR_W-1:0] wb_adr,
    input logic [DATA_W-1:0] wb_dat_i,
    input logic [1:0]        wb_sel,
    input logic [PXL_W-1:0]  obj_pxl,
    input logic [PXL_W-1:0]  scr1_pxl,
    input logic [PXL_W-1:0]  scr2_pxl,
    input logic [PXL_W-1:0]  scr3_pxl,
    input logic [8:0]        hdump,
    input logic [8:0]        vdump,
    input logic              hs,
    input logic              vs,
    input logic              lhbl,
    input logic              lvbl,
    input logic              raster,
    input logic [7:0]        red,
    input logic [7:0]        green,
    input logic [7:0]        blue
);
    timeunit 1ns;
    timeprecision 1ps;

    int errors = 0;
    int checks = 0;

    logic [7:0]  lc_model = 8'b11_10_01_00;
    logic [8:0]  raster_model = 9'd0;
    logic [15:0] pal_model [2048];
    logic [15:0] pal_last = 16'd0;
    logic [25:0] exp_q [$];
    int          mh, mv;
    logic        e_hs, e_vs, e_raster;

    initial begin
        for (int i = 0; i < 2048; i++) begin
            pal_model[i] = 16'd0;
        end
    end

    // Expected {red, green, blue, lhbl, lvbl} for one sampled pixel
    function automatic logic [25:0] expected_pixel(input logic [8:0] h, input logic [8:0] v,
            input logic [8:0] p0, input logic [8:0] p1, input logic [8:0] p2,
            input logic [8:0] p3);
        logic [8:0]  pix [4];
        logic [1:0]  id;
        logic [15:0] w;
        logic        hbl, vbl;
        logic [7:0]  r, g, b;
        pix[0] = p0;
        pix[1] = p1;
        pix[2] = p2;
        pix[3] = p3;
        // Backmost layer unless a layer in front is opaque
        id = lc_model[7:6];
        for (int i = 0; i < 4; i++) begin
            if (pix[lc_model[2*i +: 2]][3:0] != 4'd15) begin
                id = lc_model[2*i +: 2];
                break;
            end
        end
        w   = pal_model[{id, pix[id]}];
        hbl = (h >= H_ACTIVE);
        vbl = (v >= V_ACTIVE);
        r   = 8'(w[11:8]) * (8'(w[15:12]) + 8'd1);
        g   = 8'(w[7:4]) * (8'(w[15:12]) + 8'd1);
        b   = 8'(w[3:0]) * (8'(w[15:12]) + 8'd1);
        if (hbl || vbl) begin
            r = 8'd0;
            g = 8'd0;
            b = 8'd0;
        end
        return {r, g, b, ~hbl, ~vbl};
    endfunction

    task automatic check_value(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // Model update on every edge, register shadow first
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            mh       = 0;
            mv       = 0;
            e_hs     = 1'b0;
            e_vs     = 1'b0;
            e_raster = 1'b0;
        end else begin
            if (wb_ack && wb_cyc && wb_stb && wb_we) begin
                if (wb_adr[11]) begin
                    pal_last = {wb_sel[1] ? wb_dat_i[15:8] : pal_last[15:8],
                                wb_sel[0] ? wb_dat_i[7:0] : pal_last[7:0]};
                    pal_model[wb_adr[10:0]] = pal_last;
                end else if (wb_adr[10:0] == 11'd0 && wb_sel[0]) begin
                    lc_model = wb_dat_i[7:0];
                end else if (wb_adr[10:0] == 11'd1) begin
                    if (wb_sel[0]) raster_model[7:0] = wb_dat_i[7:0];
                    if (wb_sel[1]) raster_model[8] = wb_dat_i[8];
                end
            end
            exp_q.push_back(expected_pixel(hdump, vdump, obj_pxl, scr1_pxl,
                                           scr2_pxl, scr3_pxl));
            if (mh == H_TOTAL - 1) begin
                mh = 0;
                mv = (mv == V_TOTAL - 1) ? 0 : mv + 1;
            end else begin
                mh = mh + 1;
            end
            e_hs     = (mh >= H_ACTIVE + 4) && (mh <= H_ACTIVE + 11);
            e_vs     = (mv >= V_ACTIVE + 2) && (mv <= V_ACTIVE + 4);
            e_raster = (mh == 0) && (mv == int'(raster_model));
        end
    end

    // Compare in the middle of the cycle where outputs are settled
    always @(negedge clk) begin
        logic [25:0] e;
        if (!rst) begin
            check_value("hdump", mh, int'(hdump));
            check_value("vdump", mv, int'(vdump));
            check_value("hs", int'(e_hs), int'(hs));
            check_value("vs", int'(e_vs), int'(vs));
            check_value("raster", int'(e_raster), int'(raster));
            if (exp_q.size() > PIPE_DLY) begin
                e = exp_q.pop_front();
                check_value("red", int'(e[25:18]), int'(red));
                check_value("green", int'(e[17:10]), int'(green));
                check_value("blue", int'(e[9:2]), int'(blue));
                check_value("lhbl", int'(e[1]), int'(lhbl));
                check_value("lvbl", int'(e[0]), int'(lvbl));
            end
        end
    end

endmodule

/* dv/cps_video_properties.sv */
// Bound assertions on the Wishbone handshake, raster pulse and sync windows
module cps_video_properties import cps_video_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic [8:0] hdump,
    input logic       hb,
    input logic       vb,
    input logic       hs,
    input logic       vs,
    input logic       raster
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin fail_count++; $error("wb_ack held longer than one cycle"); end

    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else begin fail_count++; $error("wb_ack without a request"); end

    raster_at_h0: assert property (@(posedge clk) disable iff (rst) raster |-> hdump == 9'd0)
        else begin fail_count++; $error("raster away from line start"); end

    hs_in_blank: assert property (@(posedge clk) disable iff (rst) hs |-> hb)
        else begin fail_count++; $error("hs outside horizontal blank"); end

    vs_in_blank: assert property (@(posedge clk) disable iff (rst) vs |-> vb)
        else begin fail_count++; $error("vs outside vertical blank"); end

endmodule

bind cps_video cps_video_properties u_props (
    .clk    (clk),
    .rst    (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .hdump  (hdump),
    .hb     (hb),
    .vb     (vb),
    .hs     (hs),
    .vs     (vs),
    .raster (raster)
);

/* dv/cps_video_tb.sv */
// Testbench top: clock, reset, Wishbone accesses, random layer pixels and final report
module cps_video_tb import cps_video_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_TOTAL  = 64;
    localparam int H_ACTIVE = 48;
    localparam int V_TOTAL  = 40;
    localparam int V_ACTIVE = 32;
    localparam int FRAME    = H_TOTAL * V_TOTAL;
    localparam int ACK_WAIT = 16;

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    logic              wb_cyc = 1'b0, wb_stb = 1'b0, wb_we = 1'b0;
    logic [ADDR_W-1:0] wb_adr = '0;
    logic [DATA_W-1:0] wb_dat_i = '0;
    logic [1:0]        wb_sel = 2'b00;
    logic [DATA_W-1:0] wb_dat_o;
    logic              wb_ack;
    logic [PXL_W-1:0]  obj_pxl = '0, scr1_pxl = '0, scr2_pxl = '0, scr3_pxl = '0;
    logic [8:0]        hdump, vdump;
    logic              hs, vs, lhbl, lvbl, raster;
    logic [7:0]        red, green, blue;

    int seed = 57403;
    int transp_pct = 30;
    int errors = 0;
    int timeouts = 0;
    int total;

    always #10 clk = ~clk;

    cps_video #(
        .H_TOTAL(H_TOTAL), .H_ACTIVE(H_ACTIVE), .V_TOTAL(V_TOTAL), .V_ACTIVE(V_ACTIVE)
    ) u_dut (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_sel(wb_sel), .wb_dat_o(wb_dat_o),
        .wb_ack(wb_ack), .obj_pxl(obj_pxl), .scr1_pxl(scr1_pxl), .scr2_pxl(scr2_pxl),
        .scr3_pxl(scr3_pxl), .hdump(hdump), .vdump(vdump), .hs(hs), .vs(vs),
        .lhbl(lhbl), .lvbl(lvbl), .raster(raster), .red(red), .green(green), .blue(blue)
    );

    cps_video_checker #(
        .H_TOTAL(H_TOTAL), .H_ACTIVE(H_ACTIVE), .V_TOTAL(V_TOTAL), .V_ACTIVE(V_ACTIVE)
    ) u_chk (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_ack(wb_ack), .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_sel(wb_sel),
        .obj_pxl(obj_pxl), .scr1_pxl(scr1_pxl), .scr2_pxl(scr2_pxl), .scr3_pxl(scr3_pxl),
        .hdump(hdump), .vdump(vdump), .hs(hs), .vs(vs), .lhbl(lhbl), .lvbl(lvbl),
        .raster(raster), .red(red), .green(green), .blue(blue)
    );

    // Group 0..3 above a colour code, transparent at transp_pct percent
    function automatic logic [PXL_W-1:0] random_pixel();
        logic [1:0] grp;
        logic [3:0] code;
        grp = 2'($random(seed));
        if ({$random(seed)} % 100 < transp_pct) begin
            code = TRANSPARENT;
        end else begin
            code = 4'({$random(seed)} % 15);
        end
        return {3'd0, grp, code};
    endfunction

    always @(posedge clk) begin
        obj_pxl  <= random_pixel();
        scr1_pxl <= random_pixel();
        scr2_pxl <= random_pixel();
        scr3_pxl <= random_pixel();
    end

    task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
            input logic [DATA_W-1:0] dat, input logic [1:0] sel, output logic [DATA_W-1:0] rd);
        int n;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_i <= dat;
        wb_sel   <= sel;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!wb_ack && n < ACK_WAIT);
        // Ack is due on the edge after the request, seen one edge later
        if (!wb_ack) begin
            timeouts++;
            $display("Bus access to address %h was never acknowledged", adr);
        end else if (n != 2) begin
            errors++;
            $display("Bus access to address %h acknowledged %0d cycles late", adr, n - 2);
        end
        rd = wb_dat_o;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
            input logic [1:0] sel);
        logic [DATA_W-1:0] unused;
        bus_access(1'b1, adr, dat, sel, unused);
    endtask

    task automatic check_read(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] exp);
        logic [DATA_W-1:0] rd;
        bus_access(1'b0, adr, '0, 2'b11, rd);
        if (rd !== exp) begin
            errors++;
            $display("ERR %0t wb_dat_o expected %h got %h", $time, exp, rd);
        end
    endtask

    task automatic expect_zero(input string name, input logic [8:0] act);
        if (act !== '0) begin
            errors++;
            $display("ERR %0t %s expected 0 got %0h", $time, name, act);
        end
    endtask

    // Returns on the edge that starts vertical blank
    task automatic wait_vblank();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(hdump == 9'd0 && vdump == 9'(V_ACTIVE)) && n < 2 * FRAME);
        if (n >= 2 * FRAME) begin
            timeouts++;
            $display("Vertical blank never started");
        end
    endtask

    // Entries reachable by random pixels, one layer per vertical blank
    task automatic fill_palette();
        logic [15:0] w;
        logic [10:0] idx;
        for (int id = 0; id < 4; id++) begin
            wait_vblank();
            for (int k = 0; k < 64; k++) begin
                idx = {2'(id), 9'(k)};
                w   = 16'($random(seed));
                if (k % 8 == 0) w[15:12] = 4'd0;
                if (k % 8 == 1) w[15:12] = 4'd15;
                if (k % 16 == 5) begin
                    bus_write({1'b1, idx}, w, 2'b10);
                    bus_write({1'b1, idx}, w, 2'b01);
                end else begin
                    bus_write({1'b1, idx}, w, 2'b11);
                end
            end
        end
    endtask

    initial begin
        int pulses;
        logic [7:0] orders [4];
        orders[0] = 8'b11_10_01_00;
        orders[1] = 8'b00_01_10_11;
        orders[2] = 8'b01_11_00_10;
        orders[3] = 8'b10_00_11_01;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        #1;
        expect_zero("wb_ack", wb_ack);
        expect_zero("raster", raster);
        expect_zero("red", red);
        expect_zero("green", green);
        expect_zero("blue", blue);
        expect_zero("lhbl", lhbl);
        expect_zero("lvbl", lvbl);
        expect_zero("hdump", hdump);
        expect_zero("vdump", vdump);
        check_read(12'h000, 16'h00E4);
        check_read(12'h001, 16'h0000);
        fill_palette();
        // Register access and byte lanes
        wait_vblank();
        bus_write(12'h001, 16'h01FF, 2'b11);
        check_read(12'h001, 16'h01FF);
        bus_write(12'h001, 16'h0005, 2'b01);
        check_read(12'h001, 16'h0105);
        bus_write(12'h001, 16'h0000, 2'b10);
        check_read(12'h001, 16'h0005);
        bus_write(12'h000, 16'hFF1B, 2'b01);
        bus_write(12'h000, 16'h5500, 2'b10);
        check_read(12'h000, 16'h001B);
        check_read(12'h801, 16'h0000);
        // One raster pulse per frame on line 5
        pulses = 0;
        repeat (2 * FRAME) begin
            @(posedge clk);
            if (raster) pulses++;
        end
        if (pulses != 2) begin
            errors++;
            $display("ERR %0t raster pulses expected 2 got %0d", $time, pulses);
        end
        for (int i = 0; i < 4; i++) begin
            wait_vblank();
            bus_write(12'h000, {8'd0, orders[i]}, 2'b01);
            repeat (FRAME) @(posedge clk);
        end
        // All layers transparent, backmost entry shows
        transp_pct <= 100;
        repeat (FRAME) @(posedge clk);
        transp_pct <= 30;
        repeat (FRAME) @(posedge clk);
        total = errors + timeouts + u_chk.errors + u_dut.u_props.fail_count;
        $display("checks %0d, checker errors %0d, testbench errors %0d, timeouts %0d, asserts %0d",
                 u_chk.checks, u_chk.errors, errors, timeouts, u_dut.u_props.fail_count);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/cps_video.sv */
// Top level of the pixel back end: timing, CPU registers, layer mixer and palette
module cps_video import cps_video_pkg::*; #(
    parameter int H_TOTAL  = 512,
    parameter int H_ACTIVE = 384,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224
) (
    input  logic              clk,
    input  logic              rst,
    // CPU port
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [ADDR_W-1:0] wb_adr,
    input  logic [DATA_W-1:0] wb_dat_i,
    input  logic [1:0]        wb_sel,
    output logic [DATA_W-1:0] wb_dat_o,
    output logic              wb_ack,
    // Layer pixels, one per clk
    input  logic [PXL_W-1:0]  obj_pxl,
    input  logic [PXL_W-1:0]  scr1_pxl,
    input  logic [PXL_W-1:0]  scr2_pxl,
    input  logic [PXL_W-1:0]  scr3_pxl,
    // Video out
    output logic [8:0]        hdump,
    output logic [8:0]        vdump,
    output logic              hs,
    output logic              vs,
    output logic              lhbl,
    output logic              lvbl,
    output logic              raster,
    output logic [7:0]        red,
    output logic [7:0]        green,
    output logic [7:0]        blue
);

    logic              hb, vb, hb_d, vb_d;
    logic [7:0]        layer_ctrl;
    logic [8:0]        raster_line;
    logic              pal_we;
    logic [PAL_AW-1:0] pal_waddr, pal_addr;
    logic [DATA_W-1:0] pal_wdata;

    video_timing #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE)
    ) u_timing (
        .clk         (clk),
        .rst         (rst),
        .raster_line (raster_line),
        .hdump       (hdump),
        .vdump       (vdump),
        .hb          (hb),
        .vb          (vb),
        .hs          (hs),
        .vs          (vs),
        .raster      (raster)
    );

    video_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_sel      (wb_sel),
        .wb_dat_o    (wb_dat_o),
        .wb_ack      (wb_ack),
        .layer_ctrl  (layer_ctrl),
        .raster_line (raster_line),
        .pal_we      (pal_we),
        .pal_waddr   (pal_waddr),
        .pal_wdata   (pal_wdata)
    );

    layer_mixer u_mixer (
        .clk        (clk),
        .rst        (rst),
        .layer_ctrl (layer_ctrl),
        .obj_pxl    (obj_pxl),
        .scr1_pxl   (scr1_pxl),
        .scr2_pxl   (scr2_pxl),
        .scr3_pxl   (scr3_pxl),
        .hb         (hb),
        .vb         (vb),
        .pal_addr   (pal_addr),
        .hb_d       (hb_d),
        .vb_d       (vb_d)
    );

    palette_lookup u_pal (
        .clk       (clk),
        .rst       (rst),
        .pal_addr  (pal_addr),
        .hb_d      (hb_d),
        .vb_d      (vb_d),
        .pal_we    (pal_we),
        .pal_waddr (pal_waddr),
        .pal_wdata (pal_wdata),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .lhbl      (lhbl),
        .lvbl      (lvbl)
    );

endmodule

/* verilog/cps_video_pkg.sv */
// Shared widths, register map, pixel codes, pipeline delay and palette entry type
package cps_video_pkg;

    // Bus and pixel widths
    localparam int DATA_W = 16;
    localparam int PXL_W  = 9;
    localparam int PAL_AW = 11;
    localparam int ADDR_W = 12;

    // Address bit that steers an access to the palette
    localparam int PAL_SEL_BIT = 11;

    // Register map, word addresses below PAL_SEL_BIT
    localparam logic [PAL_SEL_BIT-1:0] REG_LAYER_CTRL = 11'd0;
    localparam logic [PAL_SEL_BIT-1:0] REG_RASTER     = 11'd1;

    // Layer ids as stored in layer_ctrl
    localparam logic [1:0] LAYER_OBJ  = 2'd0;
    localparam logic [1:0] LAYER_SCR1 = 2'd1;
    localparam logic [1:0] LAYER_SCR2 = 2'd2;
    localparam logic [1:0] LAYER_SCR3 = 2'd3;

    // Colour code with no visible pixel
    localparam logic [3:0] TRANSPARENT = 4'd15;

    // Cycles from layer sample to RGB output
    localparam int PIPE_DLY = 3;

    // Palette word, written raw and read back as fields
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic [3:0] bright;
            logic [3:0] r;
            logic [3:0] g;
            logic [3:0] b;
        } f;
    } pal_entry_t;

endpackage

/* verilog/layer_mixer.sv */
// Layer priority mixer picking the frontmost opaque pixel as a palette address
module layer_mixer import cps_video_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        layer_ctrl,
    input  logic [PXL_W-1:0]  obj_pxl,
    input  logic [PXL_W-1:0]  scr1_pxl,
    input  logic [PXL_W-1:0]  scr2_pxl,
    input  logic [PXL_W-1:0]  scr3_pxl,
    input  logic              hb,
    input  logic              vb,
    output logic [PAL_AW-1:0] pal_addr,
    output logic              hb_d,
    output logic              vb_d
);

    logic [1:0]        sel_id, cand_id;
    logic [PXL_W-1:0]  sel_pxl, cand_pxl;
    logic [PAL_AW-1:0] mix_addr;
    logic              hb_q, vb_q;

    // Pixel of one layer by its id
    function automatic logic [PXL_W-1:0] layer_pxl(input logic [1:0] id,
            input logic [PXL_W-1:0] p0, input logic [PXL_W-1:0] p1,
            input logic [PXL_W-1:0] p2, input logic [PXL_W-1:0] p3);
        case (id)
            LAYER_OBJ:  return p0;
            LAYER_SCR1: return p1;
            LAYER_SCR2: return p2;
            default:    return p3;
        endcase
    endfunction

    // Walk from the back so the frontmost opaque layer wins last
    always_comb begin
        sel_id  = layer_ctrl[7:6];
        sel_pxl = layer_pxl(sel_id, obj_pxl, scr1_pxl, scr2_pxl, scr3_pxl);
        for (int i = 2; i >= 0; i--) begin
            cand_id  = layer_ctrl[2*i +: 2];
            cand_pxl = layer_pxl(cand_id, obj_pxl, scr1_pxl, scr2_pxl, scr3_pxl);
            if (cand_pxl[3:0] != TRANSPARENT) begin
                sel_id  = cand_id;
                sel_pxl = cand_pxl;
            end
        end
    end

    // Sample stage, then the palette address stage
    always_ff @(posedge clk) begin
        mix_addr <= {sel_id, sel_pxl};
        pal_addr <= mix_addr;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_q <= 1'b1;
            vb_q <= 1'b1;
            hb_d <= 1'b1;
            vb_d <= 1'b1;
        end else begin
            hb_q <= hb;
            vb_q <= vb;
            hb_d <= hb_q;
            vb_d <= vb_q;
        end
    end

endmodule

/* verilog/palette_lookup.sv */
// Palette RAM with synchronous read, brightness scaling and blank-aligned RGB output
module palette_lookup import cps_video_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [PAL_AW-1:0] pal_addr,
    input  logic              hb_d,
    input  logic              vb_d,
    input  logic              pal_we,
    input  logic [PAL_AW-1:0] pal_waddr,
    input  logic [DATA_W-1:0] pal_wdata,
    output logic [7:0]        red,
    output logic [7:0]        green,
    output logic [7:0]        blue,
    output logic              lhbl,
    output logic              lvbl
);

    pal_entry_t pal_mem [2**PAL_AW];
    pal_entry_t rd_entry;
    logic       hb_r, vb_r, blank;

    // Channel times brightness plus one, at most 240
    function automatic logic [7:0] scale(input logic [3:0] ch, input logic [3:0] br);
        logic [7:0] k;
        k = {4'd0, br} + 8'd1;
        return {4'd0, ch} * k;
    endfunction

    initial begin
        for (int i = 0; i < 2**PAL_AW; i++) begin
            pal_mem[i] = '0;
        end
    end

    // CPU write port and pixel read port
    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_mem[pal_waddr].raw <= pal_wdata;
        end
        rd_entry <= pal_mem[pal_addr];
    end

    assign blank = hb_r | vb_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_r  <= 1'b1;
            vb_r  <= 1'b1;
            red   <= 8'd0;
            green <= 8'd0;
            blue  <= 8'd0;
            lhbl  <= 1'b0;
            lvbl  <= 1'b0;
        end else begin
            hb_r  <= hb_d;
            vb_r  <= vb_d;
            red   <= blank ? 8'd0 : scale(rd_entry.f.r, rd_entry.f.bright);
            green <= blank ? 8'd0 : scale(rd_entry.f.g, rd_entry.f.bright);
            blue  <= blank ? 8'd0 : scale(rd_entry.f.b, rd_entry.f.bright);
            lhbl  <= ~hb_r;
            lvbl  <= ~vb_r;
        end
    end

endmodule

/* verilog/video_regs.sv */
// Wishbone classic slave with layer order and raster registers and palette write port
module video_regs import cps_video_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [ADDR_W-1:0] wb_adr,
    input  logic [DATA_W-1:0] wb_dat_i,
    input  logic [1:0]        wb_sel,
    output logic [DATA_W-1:0] wb_dat_o,
    output logic              wb_ack,
    output logic [7:0]        layer_ctrl,
    output logic [8:0]        raster_line,
    output logic              pal_we,
    output logic [PAL_AW-1:0] pal_waddr,
    output logic [DATA_W-1:0] pal_wdata
);

    logic              acc, wr, pal_sel;
    logic [DATA_W-1:0] pal_shadow;
    logic [DATA_W-1:0] rd_data;

    // Access accepted on the edge that raises ack
    assign acc     = wb_cyc & wb_stb & ~wb_ack;
    assign wr      = acc & wb_we;
    assign pal_sel = wb_adr[PAL_SEL_BIT];

    // Lanes left out of a palette write come from the last palette word
    assign pal_we    = wr & pal_sel;
    assign pal_waddr = wb_adr[PAL_AW-1:0];
    assign pal_wdata = {wb_sel[1] ? wb_dat_i[15:8] : pal_shadow[15:8],
                        wb_sel[0] ? wb_dat_i[7:0]  : pal_shadow[7:0]};

    always_comb begin
        rd_data = '0;
        if (!pal_sel) begin
            if (wb_adr[PAL_SEL_BIT-1:0] == REG_LAYER_CTRL) begin
                rd_data = {8'd0, layer_ctrl};
            end else if (wb_adr[PAL_SEL_BIT-1:0] == REG_RASTER) begin
                rd_data = {7'd0, raster_line};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack      <= 1'b0;
            layer_ctrl  <= 8'b11_10_01_00;
            raster_line <= 9'd0;
            pal_shadow  <= '0;
        end else begin
            wb_ack <= acc;
            if (wr && !pal_sel && wb_adr[PAL_SEL_BIT-1:0] == REG_LAYER_CTRL && wb_sel[0]) begin
                layer_ctrl <= wb_dat_i[7:0];
            end
            if (wr && !pal_sel && wb_adr[PAL_SEL_BIT-1:0] == REG_RASTER) begin
                if (wb_sel[0]) raster_line[7:0] <= wb_dat_i[7:0];
                if (wb_sel[1]) raster_line[8]   <= wb_dat_i[8];
            end
            if (pal_we) begin
                pal_shadow <= pal_wdata;
            end
        end
    end

    // Read data valid alongside ack
    always_ff @(posedge clk) begin
        if (acc && !wb_we) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

/* verilog/video_timing.sv */
// Raster counters, sync and blanking windows and the raster line interrupt
module video_timing #(
    parameter int H_TOTAL  = 512,
    parameter int H_ACTIVE = 384,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [8:0] raster_line,
    output logic [8:0] hdump,
    output logic [8:0] vdump,
    output logic       hb,
    output logic       vb,
    output logic       hs,
    output logic       vs,
    output logic       raster
);

    logic [8:0] h_next, v_next;
    logic       h_wrap;

    // Next counter values, so every decoded flag lines up with the counters
    always_comb begin
        h_wrap = (hdump == 9'(H_TOTAL - 1));
        h_next = h_wrap ? 9'd0 : hdump + 9'd1;
        v_next = vdump;
        if (h_wrap) begin
            v_next = (vdump == 9'(V_TOTAL - 1)) ? 9'd0 : vdump + 9'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump  <= 9'd0;
            vdump  <= 9'd0;
            hb     <= 1'b0;
            vb     <= 1'b0;
            hs     <= 1'b0;
            vs     <= 1'b0;
            raster <= 1'b0;
        end else begin
            hdump <= h_next;
            vdump <= v_next;
            hb    <= h_next >= H_ACTIVE;
            vb    <= v_next >= V_ACTIVE;
            // Sync pulses sit inside the blanking intervals
            hs    <= (h_next >= H_ACTIVE + 4) && (h_next <= H_ACTIVE + 11);
            vs    <= (v_next >= V_ACTIVE + 2) && (v_next <= V_ACTIVE + 4);
            // One pulse at the start of the selected line
            raster <= (h_next == 9'd0) && (v_next == raster_line);
        end
    end

endmodule
